/* common/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

	// isa widths
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// condition code, bit 2 is n, bit 1 is z, bit 0 is p
	typedef logic [2:0] lc3b_nzp;

	// instruction bits 15:12, only the operate group is implemented
	typedef enum logic [3:0] {
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_shf = 4'b1101
	} lc3b_opcode;

	// operations carried from decode into execute
	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_lshf,
		alu_rshfl,
		alu_rshfa
	} lc3b_alu_op;

endpackage : lc3b_pkg

`default_nettype wire

/* src/lc3b_regfile.sv */
`default_nettype none

module lc3b_regfile
	import lc3b_pkg::*;
(
	input logic clk,
	input logic reset,

	// read ports
	input lc3b_reg rd_a,
	input lc3b_reg rd_b,
	output lc3b_word q_a,
	output lc3b_word q_b,

	// write port
	input logic wen,
	input lc3b_reg wr,
	input lc3b_word wdata
);

lc3b_word regs [8];

// no write bypass here, decode forwards the retiring write itself
assign q_a = regs[rd_a];
assign q_b = regs[rd_b];

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < 8; i++) begin
			regs[i] <= '0;
		end
	end else if (wen) begin
		regs[wr] <= wdata;
	end
end

endmodule : lc3b_regfile

`default_nettype wire

/* src/lc3b_decode.sv */
`default_nettype none

module lc3b_decode
	import lc3b_pkg::*;
(
	input logic clk,
	input logic reset,

	// instruction stream
	input logic instr_valid,
	input lc3b_word instr,
	output logic instr_ready,

	// register file reads
	output lc3b_reg rd_a,
	output lc3b_reg rd_b,
	input lc3b_word q_a,
	input lc3b_word q_b,

	// forward sources
	input logic fwd_x_wen,
	input lc3b_reg fwd_x_dr,
	input lc3b_word fwd_x_data,
	input logic rf_wen,
	input lc3b_reg rf_dr,
	input lc3b_word rf_data,

	// decode/execute register
	input logic d_ready,
	output logic d_valid,
	output lc3b_alu_op d_op,
	output lc3b_reg d_dr,
	output logic d_wen,
	output lc3b_word d_a,
	output lc3b_word d_b
);

lc3b_opcode opcode;
lc3b_word imm5;
lc3b_word imm4;
lc3b_word src_a;
lc3b_word src_b;
lc3b_alu_op op;
logic wen;
lc3b_word a;
lc3b_word b;
logic transfer;

assign opcode = lc3b_opcode'(instr[15:12]);
assign imm5 = {{11{instr[4]}}, instr[4:0]};
assign imm4 = {12'b0, instr[3:0]};

assign rd_a = instr[8:6];
assign rd_b = instr[2:0];

assign instr_ready = d_ready;
assign transfer = instr_valid && instr_ready;

// execute holds the youngest write, so it goes first
function automatic lc3b_word forward(input lc3b_reg r, input lc3b_word q);
	if (fwd_x_wen && fwd_x_dr == r)
		return fwd_x_data;
	else if (rf_wen && rf_dr == r)
		return rf_data;
	return q;
endfunction

always_comb begin
	src_a = forward(rd_a, q_a);
	src_b = forward(rd_b, q_b);
end

always_comb begin
	op = alu_add;
	wen = 1'b1;
	a = src_a;
	b = instr[5] ? imm5 : src_b;
	case (opcode)
		op_add: op = alu_add;
		op_and: op = alu_and;
		op_not: begin
			op = alu_not;
			b = 16'hffff;
		end
		op_shf: begin
			b = imm4;
			// bit 4 picks right, bit 5 picks arithmetic
			if (!instr[4])
				op = alu_lshf;
			else if (instr[5])
				op = alu_rshfa;
			else
				op = alu_rshfl;
		end
		default: begin
			// illegal, retires as a zero result with no write
			wen = 1'b0;
			a = '0;
			b = '0;
		end
	endcase
end

always_ff @(posedge clk) begin
	if (reset)
		d_valid <= 1'b0;
	else if (transfer)
		d_valid <= 1'b1;
	else if (d_ready)
		d_valid <= 1'b0;
end

always_ff @(posedge clk) begin
	if (transfer) begin
		d_op <= op;
		d_dr <= instr[11:9];
		d_wen <= wen;
		d_a <= a;
		d_b <= b;
	end
end

endmodule : lc3b_decode

`default_nettype wire

/* src/lc3b_execute.sv */
`default_nettype none

module lc3b_execute
	import lc3b_pkg::*;
(
	input logic clk,
	input logic reset,

	// decode/execute register
	input logic d_valid,
	input lc3b_alu_op d_op,
	input lc3b_reg d_dr,
	input logic d_wen,
	input lc3b_word d_a,
	input lc3b_word d_b,
	output logic d_ready,

	// forward source into decode
	output logic fwd_x_wen,
	output lc3b_reg fwd_x_dr,
	output lc3b_word fwd_x_data,

	// execute/write-back register
	input logic x_ready,
	output logic x_valid,
	output lc3b_reg x_dr,
	output logic x_wen,
	output lc3b_word x_data
);

lc3b_word result;
logic [3:0] shamt;

assign shamt = d_b[3:0];

always_comb begin
	case (d_op)
		alu_add: result = d_a + d_b;
		alu_and: result = d_a & d_b;
		// b is all ones for not
		alu_not: result = d_a ^ d_b;
		alu_lshf: result = d_a << shamt;
		alu_rshfl: result = d_a >> shamt;
		alu_rshfa: result = lc3b_word'($signed(d_a) >>> shamt);
		default: result = '0;
	endcase
end

assign fwd_x_wen = d_valid && d_wen;
assign fwd_x_dr = d_dr;
assign fwd_x_data = result;

// only accept while write back can take the older instruction, so a
// pending write in write back is always retiring when decode reads
assign d_ready = x_ready;

always_ff @(posedge clk) begin
	if (reset)
		x_valid <= 1'b0;
	else if (x_ready)
		x_valid <= d_valid;
end

always_ff @(posedge clk) begin
	if (x_ready) begin
		x_dr <= d_dr;
		x_wen <= d_wen;
		x_data <= result;
	end
end

endmodule : lc3b_execute

`default_nettype wire

/* src/lc3b_write_back.sv */
`default_nettype none

module lc3b_write_back
	import lc3b_pkg::*;
(
	input logic clk,
	input logic reset,

	// execute/write-back register
	input logic x_valid,
	input lc3b_reg x_dr,
	input logic x_wen,
	input lc3b_word x_data,
	output logic x_ready,

	// retire record
	output logic retire_valid,
	input logic retire_ready,
	output lc3b_reg retire_dr,
	output lc3b_word retire_data,
	output logic retire_wen,
	output lc3b_nzp retire_nzp,

	// register file write, also forwarded to decode
	output logic rf_wen,
	output lc3b_reg rf_dr,
	output lc3b_word rf_data
);

lc3b_nzp cc;
lc3b_nzp new_cc;
logic retire;

always_comb begin
	if (x_data[15])
		new_cc = 3'b100;
	else if (x_data == '0)
		new_cc = 3'b010;
	else
		new_cc = 3'b001;
end

assign x_ready = !x_valid || retire_ready;
assign retire = x_valid && retire_ready;

assign retire_valid = x_valid;
assign retire_dr = x_dr;
assign retire_data = x_data;
assign retire_wen = x_wen;
assign retire_nzp = x_wen ? new_cc : cc;

assign rf_wen = retire && x_wen;
assign rf_dr = x_dr;
assign rf_data = x_data;

// cc moves only with a writing retire
always_ff @(posedge clk) begin
	if (reset)
		cc <= '0;
	else if (rf_wen)
		cc <= new_cc;
end

endmodule : lc3b_write_back

`default_nettype wire

/* src/lc3b_core.sv */
`default_nettype none

module lc3b_core
	import lc3b_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic instr_valid,
	input lc3b_word instr,
	output logic instr_ready,

	output logic retire_valid,
	input logic retire_ready,
	output lc3b_reg retire_dr,
	output lc3b_word retire_data,
	output logic retire_wen,
	output lc3b_nzp retire_nzp
);

// register file
lc3b_reg rd_a;
lc3b_reg rd_b;
lc3b_word q_a;
lc3b_word q_b;
logic rf_wen;
lc3b_reg rf_dr;
lc3b_word rf_data;

// decode/execute
logic d_valid;
logic d_ready;
lc3b_alu_op d_op;
lc3b_reg d_dr;
logic d_wen;
lc3b_word d_a;
lc3b_word d_b;

// execute forward
logic fwd_x_wen;
lc3b_reg fwd_x_dr;
lc3b_word fwd_x_data;

// execute/write-back
logic x_valid;
logic x_ready;
lc3b_reg x_dr;
logic x_wen;
lc3b_word x_data;

lc3b_regfile regfile_int (
	.clk,
	.reset,
	.rd_a,
	.rd_b,
	.q_a,
	.q_b,
	.wen(rf_wen),
	.wr(rf_dr),
	.wdata(rf_data)
);

lc3b_decode decode_int (
	.clk,
	.reset,
	.instr_valid,
	.instr,
	.instr_ready,
	.rd_a,
	.rd_b,
	.q_a,
	.q_b,
	.fwd_x_wen,
	.fwd_x_dr,
	.fwd_x_data,
	.rf_wen,
	.rf_dr,
	.rf_data,
	.d_ready,
	.d_valid,
	.d_op,
	.d_dr,
	.d_wen,
	.d_a,
	.d_b
);

lc3b_execute execute_int (
	.clk,
	.reset,
	.d_valid,
	.d_op,
	.d_dr,
	.d_wen,
	.d_a,
	.d_b,
	.d_ready,
	.fwd_x_wen,
	.fwd_x_dr,
	.fwd_x_data,
	.x_ready,
	.x_valid,
	.x_dr,
	.x_wen,
	.x_data
);

lc3b_write_back write_back_int (
	.clk,
	.reset,
	.x_valid,
	.x_dr,
	.x_wen,
	.x_data,
	.x_ready,
	.retire_valid,
	.retire_ready,
	.retire_dr,
	.retire_data,
	.retire_wen,
	.retire_nzp,
	.rf_wen,
	.rf_dr,
	.rf_data
);

endmodule : lc3b_core

`default_nettype wire

/* sim/lc3b_core_tb.sv */
`default_nettype none

module lc3b_core_tb;

timeunit 1ns;
timeprecision 1ps;

logic clk;
logic reset;
logic instr_valid;
logic [15:0] instr;
logic instr_ready;
logic retire_valid;
logic retire_ready;
logic [2:0] retire_dr;
logic [15:0] retire_data;
logic retire_wen;
logic [2:0] retire_nzp;

// vectors, one entry per instruction
string names[$];
logic [15:0] instrs[$];
logic [2:0] exp_dr[$];
logic [15:0] exp_data[$];
logic exp_wen[$];
logic [2:0] exp_nzp[$];

int num_vectors = 0;
bit vectors_loaded = 0;
bit load_error = 0;
int seed = 32'h8718_1fde;
int checked = 0;
int pass_count = 0;
int fail_count = 0;
int stray_retires = 0;
int field_errors = 0;

lc3b_core DUT (
	.clk,
	.reset,
	.instr_valid,
	.instr,
	.instr_ready,
	.retire_valid,
	.retire_ready,
	.retire_dr,
	.retire_data,
	.retire_wen,
	.retire_nzp
);

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

task automatic load_vectors();
	int fd;
	int count;
	string line;
	string name;
	int word;
	int dr;
	int data;
	int wen;
	int nzp;
	fd = $fopen("sim/lc3b_vectors.txt", "r");
	if (fd == 0) begin
		$display("cannot open the vector file sim/lc3b_vectors.txt");
		load_error = 1;
		return;
	end
	while ($fgets(line, fd) != 0) begin
		if (line.len() < 2 || line.substr(0, 0) == "#")
			continue;
		count = $sscanf(line, "%s %h %d %h %d %b", name, word, dr, data, wen, nzp);
		if (count != 6) begin
			$display("malformed vector line: %s", line);
			load_error = 1;
			continue;
		end
		names.push_back(name);
		instrs.push_back(word[15:0]);
		exp_dr.push_back(dr[2:0]);
		exp_data.push_back(data[15:0]);
		exp_wen.push_back(wen[0]);
		exp_nzp.push_back(nzp[2:0]);
	end
	$fclose(fd);
	num_vectors = names.size();
endtask

task automatic abort_run(input string reason);
	$display("%s", reason);
	$display("TEST RESULT: FAIL");
	$finish;
endtask

task automatic compare_value(input string test, input string field,
		input logic [15:0] expected, input logic [15:0] actual);
	if (expected !== actual) begin
		$display("MISMATCH %s %s expected %h actual %h", test, field, expected, actual);
		field_errors++;
	end
endtask

task automatic check_retire();
	int i;
	i = checked;
	if (i >= num_vectors) begin
		$display("unexpected retire with dr %0d and data %h after the last instruction",
			retire_dr, retire_data);
		stray_retires++;
		return;
	end
	field_errors = 0;
	compare_value(names[i], "dr", 16'(exp_dr[i]), 16'(retire_dr));
	compare_value(names[i], "data", exp_data[i], retire_data);
	compare_value(names[i], "wen", 16'(exp_wen[i]), 16'(retire_wen));
	compare_value(names[i], "nzp", 16'(exp_nzp[i]), 16'(retire_nzp));
	if (field_errors == 0) begin
		$display("%-20s passed", names[i]);
		pass_count++;
	end else begin
		$display("%-20s failed", names[i]);
		fail_count++;
	end
	checked++;
endtask

// source and sink share one random stream so the sequence is fixed
task automatic drive_stimulus();
	int sent;
	sent = 0;
	forever begin
		@(posedge clk);
		if (instr_valid && instr_ready)
			sent++;
		if (!instr_valid || instr_ready) begin
			if (sent < num_vectors && ($random(seed) & 3) != 0) begin
				instr_valid <= 1'b1;
				instr <= instrs[sent];
			end else begin
				instr_valid <= 1'b0;
			end
		end
		retire_ready <= ($random(seed) & 3) != 0;
	end
endtask

// retire record is sampled before the edge updates it
always @(posedge clk) begin
	if (retire_valid && retire_ready)
		check_retire();
end

initial begin : main
	reset = 1'b1;
	instr_valid = 1'b0;
	instr = '0;
	retire_ready = 1'b0;
	load_vectors();
	vectors_loaded = 1;
	if (load_error || num_vectors == 0) begin
		abort_run("no usable vectors could be read, nothing was run");
	end else begin
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		fork
			drive_stimulus();
		join_none
		wait (checked == num_vectors);
		// a few more cycles to catch a duplicated retire
		repeat (5) @(posedge clk);
		$display("%0d tests passed, %0d failed, %0d unexpected retires",
			pass_count, fail_count, stray_retires);
		if (fail_count == 0 && stray_retires == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end
end

initial begin : watchdog
	wait (vectors_loaded);
	repeat (num_vectors * 20 + 5) @(posedge clk);
	$display("retires stopped arriving, %0d of %0d instructions retired in time",
		checked, num_vectors);
	abort_run("the run was stopped by the watchdog");
end

endmodule : lc3b_core_tb

`default_nettype wire

/* sim/lc3b_vectors.txt */
# test name, instruction (hex), expected dr (dec), data (hex), wen (dec), nzp (bin)
# registers start at zero, each line follows from the lines above it
add_imm_pos      1225 1 0005 1 001
add_imm_neg      143D 2 FFFD 1 100
and_imm_mask     56AC 3 000C 1 001
and_imm_zero     5860 4 0000 1 010
add_reg          1A42 5 0002 1 001
add_reg_dep      1B45 5 0004 1 001
and_reg_dep      5D43 6 0004 1 001
not_reg          9FBF 7 FFFB 1 100
not_reg_dep      9FFF 7 0004 1 001
add_reg_neg      1282 1 FFFA 1 100
illegal_br       0A55 5 0000 0 100
lshf_3           D543 2 0020 1 001
rshfl_4_neg      D654 3 0FFF 1 001
rshfa_4_neg      D874 4 FFFF 1 100
lshf_15_zero     DDCF 6 0000 1 010
rshfa_0          D130 0 FFFF 1 100
rshfl_15         DA5F 5 0001 1 001
illegal_trap     F025 0 0000 0 001
add_after_ill    1D40 6 0000 1 010
rshfa_2_pos      D2F2 1 03FF 1 001

/* src.f */
common/lc3b_pkg.sv
src/lc3b_regfile.sv
src/lc3b_decode.sv
src/lc3b_execute.sv
src/lc3b_write_back.sv
src/lc3b_core.sv
sim/lc3b_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the lc3b_core testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timescale 1ns/1ps --top-module lc3b_core_tb -f src.f \
	-o lc3b_core_tb 2>&1 | tee "$log" &&
./obj_dir/lc3b_core_tb 2>&1 | tee -a "$log" ||
{ echo "build or simulation did not complete"; exit 1; }

grep -q "TEST RESULT: FAIL" "$log" &&
{ echo "simulation reported failure, see $log"; exit 1; }

echo "simulation finished without failure"
exit 0
